/* strand_params.svh */
// Strand select stage configuration
// Strand count, instruction encodings and strided lane geometry
`ifndef STRAND_PARAMS_SVH
`define STRAND_PARAMS_SVH

// Hardware strands per core
`define STRANDS_PER_CORE 4
`define STRAND_INDEX_WIDTH 2

// All-zero word issued when no strand wins
`define NOP 32'h00000000

// Top nibble of a strided vector load or store
`define STRIDED_OPCODE 4'b1110

// Lanes walked by one strided instruction
`define LANE_COUNT 16
// Byte step between consecutive lanes
`define LANE_STRIDE 32'd4

`endif

/* strand_pkg.sv */
// Strand select types
// Per-strand state, fetch slot, rollback request and issue packet
package strand_pkg;

`include "strand_params.svh"

	// Per-strand scheduling state
	typedef enum logic [1:0]
	{
		STRAND_WAIT_FETCH,
		STRAND_READY,
		STRAND_SUSPENDED,
		STRAND_RECOVER
	} strand_state_t;

	// One strand's current instruction from fetch
	typedef struct packed
	{
		logic valid;
		logic [31:0] instruction;
		logic [31:0] pc;
		logic branch_predicted;
		logic long_latency;
	} fetch_slot_t;

	// Strobes and restart point from the rollback controller
	typedef struct packed
	{
		logic rollback;
		logic retry;
		logic suspend;
		logic resume;
		logic [31:0] strided_offset;
		logic [3:0] reg_lane;
	} rollback_req_t;

	// Registered output toward decode
	typedef struct packed
	{
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [3:0] reg_lane;
		logic [31:0] strided_offset;
		logic [`STRAND_INDEX_WIDTH - 1:0] strand;
		logic branch_predicted;
		logic long_latency;
	} issue_packet_t;

endpackage

/* strand_fsm.sv */
// Per-strand scheduling FSM
// Tracks readiness, suspend and rollback recovery, and walks a strided
// instruction through its lanes before asking fetch for the next one
`timescale 1ns/10ps

`include "strand_params.svh"

module strand_fsm
	import strand_pkg::*;
(
	input clk,
	input reset,
	input fetch_slot_t slot,
	input rollback_req_t rollback,
	input logic granted,
	output logic instruction_req,
	output logic ready,
	output logic [3:0] reg_lane,
	output logic [31:0] strided_offset
);

	// Strided walk starts at the top lane
	localparam logic [3:0] LAST_LANE = 4'(`LANE_COUNT - 1);

	strand_state_t state;
	strand_state_t state_nxt;
	logic [3:0] lane_nxt;
	logic [31:0] offset_nxt;
	logic is_strided;
	logic override;
	logic consume;

	assign is_strided = slot.instruction[31:28] == `STRIDED_OPCODE;

	// Rollback side events win over a grant in the same cycle
	assign override = rollback.rollback || rollback.suspend || rollback.retry;

	// Slot used up on a plain grant or on the final lane
	assign consume = granted && !override && (!is_strided || reg_lane == 4'd0);
	assign instruction_req = consume;

	assign ready = state == STRAND_READY;

	always_comb
	begin
		state_nxt = state;
		lane_nxt = reg_lane;
		offset_nxt = strided_offset;

		if (rollback.rollback)
		begin
			// Restart point from the rollback controller
			state_nxt = STRAND_RECOVER;
			lane_nxt = rollback.reg_lane;
			offset_nxt = rollback.strided_offset;
		end
		else if (rollback.suspend)
			state_nxt = STRAND_SUSPENDED;
		else if (rollback.retry)
			state_nxt = STRAND_RECOVER;
		else if (rollback.resume && state == STRAND_SUSPENDED)
		begin
			// Same slot is still held by fetch
			state_nxt = slot.valid ? STRAND_READY : STRAND_WAIT_FETCH;
		end
		else
		begin
			case (state)
				STRAND_WAIT_FETCH:
				begin
					if (slot.valid)
						state_nxt = STRAND_READY;
				end

				STRAND_READY:
				begin
					if (consume)
					begin
						// Next instruction arrives from fetch
						state_nxt = STRAND_WAIT_FETCH;
						lane_nxt = LAST_LANE;
						offset_nxt = 32'd0;
					end
					else if (granted)
					begin
						// Step to the next lane
						lane_nxt = reg_lane - 4'd1;
						offset_nxt = strided_offset + `LANE_STRIDE;
					end
				end

				// One bubble while fetch is redirected
				STRAND_RECOVER:
					state_nxt = STRAND_WAIT_FETCH;

				default:
					state_nxt = state;
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= STRAND_WAIT_FETCH;
			reg_lane <= LAST_LANE;
			strided_offset <= 32'd0;
		end
		else
		begin
			state <= state_nxt;
			reg_lane <= lane_nxt;
			strided_offset <= offset_nxt;
		end
	end

endmodule

/* issue_arbiter.sv */
// Round-robin issue arbiter
// Grants the first requester at or after the priority position,
// then moves priority just past the winner
`timescale 1ns/10ps

`include "strand_params.svh"

module issue_arbiter(
	input clk,
	input reset,
	input logic [`STRANDS_PER_CORE - 1:0] request,
	output logic [`STRANDS_PER_CORE - 1:0] grant_oh,
	output logic [`STRAND_INDEX_WIDTH - 1:0] grant_index
);

	localparam int N = `STRANDS_PER_CORE;

	// One-hot position with first priority
	logic [N - 1:0] priority_oh;
	logic [2 * N - 1:0] request_dbl;
	logic [2 * N - 1:0] grant_dbl;

	// Doubled vector handles the wrap past the top strand
	assign request_dbl = {request, request};

	// Lowest set request bit at or above the priority bit
	assign grant_dbl = request_dbl & ~(request_dbl - {{N{1'b0}}, priority_oh});
	assign grant_oh = grant_dbl[N - 1:0] | grant_dbl[2 * N - 1:N];

	// One-hot to index
	always_comb
	begin
		grant_index = '0;
		for (int i = 0; i < N; i++)
		begin
			if (grant_oh[i])
				grant_index = `STRAND_INDEX_WIDTH'(i);
		end
	end

	// Priority moves to the strand after the winner
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_oh <= {{(N - 1){1'b0}}, 1'b1};
		else if (|grant_oh)
			priority_oh <= {grant_oh[N - 2:0], grant_oh[N - 1]};
	end

endmodule

/* strand_select_stage.sv */
// Strand select stage
// Picks one ready strand per cycle for decode, holds back short ops that
// would collide with a long op at the execute merge, registers the issue packet
`timescale 1ns/10ps

`include "strand_params.svh"

module strand_select_stage
	import strand_pkg::*;
(
	input clk,
	input reset,
	input logic [`STRANDS_PER_CORE - 1:0] strand_enable,
	input fetch_slot_t [`STRANDS_PER_CORE - 1:0] fetch,
	input rollback_req_t [`STRANDS_PER_CORE - 1:0] rollback,
	output logic [`STRANDS_PER_CORE - 1:0] instruction_req,
	output issue_packet_t issue,
	output logic issue_event
);

	// Idle issue slot
	localparam issue_packet_t NOP_PACKET = '{
		pc: 32'd0,
		instruction: `NOP,
		reg_lane: 4'd0,
		strided_offset: 32'd0,
		strand: '0,
		branch_predicted: 1'b0,
		long_latency: 1'b0
	};

	logic [`STRANDS_PER_CORE - 1:0] strand_ready;
	logic [`STRANDS_PER_CORE - 1:0] short_latency;
	logic [`STRANDS_PER_CORE - 1:0] execute_hazard;
	logic [`STRANDS_PER_CORE - 1:0] request;
	logic [`STRANDS_PER_CORE - 1:0] grant_oh;
	logic [`STRAND_INDEX_WIDTH - 1:0] grant_index;
	logic [`STRANDS_PER_CORE - 1:0][3:0] reg_lane;
	logic [`STRANDS_PER_CORE - 1:0][31:0] strided_offset;

	// One bit per stage of the long pipeline, set for a long op
	logic [2:0] writeback_shift;
	logic issue_long_latency;
	logic any_grant;
	fetch_slot_t selected_slot;
	issue_packet_t issue_nxt;

	genvar i;

	generate
		for (i = 0; i < `STRANDS_PER_CORE; i++)
		begin : strand
			strand_fsm fsm_inst(
				.clk(clk),
				.reset(reset),
				.slot(fetch[i]),
				.rollback(rollback[i]),
				.granted(grant_oh[i]),
				.instruction_req(instruction_req[i]),
				.ready(strand_ready[i]),
				.reg_lane(reg_lane[i]),
				.strided_offset(strided_offset[i])
			);

			// NOP never reaches writeback, so it never conflicts
			assign short_latency[i] = !fetch[i].long_latency
				&& fetch[i].instruction != `NOP;
		end
	endgenerate

	// Long op issued three cycles ago lands at the merge with this one
	assign execute_hazard = {`STRANDS_PER_CORE{writeback_shift[2]}} & short_latency;
	assign request = strand_ready & strand_enable & ~execute_hazard;

	issue_arbiter arbiter_inst(
		.clk(clk),
		.reset(reset),
		.request(request),
		.grant_oh(grant_oh),
		.grant_index(grant_index)
	);

	assign any_grant = |grant_oh;

	// Winner's slot by index
	assign selected_slot = fetch[grant_index];
	assign issue_long_latency = any_grant && selected_slot.long_latency;

	always_comb
	begin
		if (any_grant)
		begin
			issue_nxt.pc = selected_slot.pc;
			issue_nxt.instruction = selected_slot.instruction;
			issue_nxt.reg_lane = reg_lane[grant_index];
			issue_nxt.strided_offset = strided_offset[grant_index];
			issue_nxt.strand = grant_index;
			issue_nxt.branch_predicted = selected_slot.branch_predicted;
			issue_nxt.long_latency = selected_slot.long_latency;
		end
		else
		begin
			// Bubble keeps lane and offset of the last issue
			issue_nxt = NOP_PACKET;
			issue_nxt.reg_lane = issue.reg_lane;
			issue_nxt.strided_offset = issue.strided_offset;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			writeback_shift <= 3'b000;
			issue <= NOP_PACKET;
			issue_event <= 1'b0;
		end
		else
		begin
			// Shifts every cycle and bubbles shift in zero
			writeback_shift <= {writeback_shift[1:0], issue_long_latency};
			issue <= issue_nxt;
			issue_event <= any_grant;
		end
	end

endmodule

/* strand_select_tb_ref.svh */
// Strand select reference model
// Expected strided lane walk, round-robin winner and writeback conflict rule
`ifndef STRAND_SELECT_TB_REF_SVH
`define STRAND_SELECT_TB_REF_SVH

// Lanes count down from the starting lane, one per grant
function automatic logic [3:0] strided_lane(logic [3:0] start, int step);
	return start - 4'(step);
endfunction

// Offset grows by one stride per grant
function automatic logic [31:0] strided_offset_at(logic [31:0] start, int step);
	return start + step * `LANE_STRIDE;
endfunction

// First candidate after the last winner, rising index with wrap
function automatic int next_rr(int last, logic [`STRANDS_PER_CORE - 1:0] candidates);
	int idx;
	for (int i = 1; i <= `STRANDS_PER_CORE; i++)
	begin
		idx = (last + i) % `STRANDS_PER_CORE;
		if (candidates[idx])
			return idx;
	end
	return -1;
endfunction

// Short op must not follow a long op by exactly three issue slots
function automatic logic conflict_free(logic [2:0] long_hist, logic valid, logic long_op,
	logic [31:0] instr);
	logic short_op;
	short_op = valid && !long_op && instr != `NOP;
	return !(long_hist[2] && short_op);
endfunction

`endif

/* strand_select_tb.sv */
// Strand select stage testbench
// Fetch and rollback models, phased stimulus, checks against reference model
`timescale 1ns/10ps

`include "strand_params.svh"

module strand_select_tb
	import strand_pkg::*;
();

	localparam int N = `STRANDS_PER_CORE;

	logic clk = 1'b0;
	logic reset;
	logic [N - 1:0] strand_enable;
	fetch_slot_t [N - 1:0] fetch;
	rollback_req_t [N - 1:0] rollback;
	logic [N - 1:0] instruction_req;
	issue_packet_t issue;
	logic issue_event;

	// Per-strand programs, fetch pointer and checker pointer
	fetch_slot_t prog [N][16];
	int len [N];
	int ptr [N];
	int exp_ptr [N];
	int step [N];
	logic [3:0] start_lane [N];
	logic [31:0] start_off [N];
	logic [N - 1:0] req_seen;
	logic [N - 1:0] req_prev;
	logic [N - 1:0] en_seen;
	logic [N - 1:0] suspended;
	logic [2:0] long_hist;
	int last_winner = N - 1;
	bit rr_check;
	int errors;
	int checks;
	int k;

	`include "strand_select_tb_ref.svh"

	strand_select_stage dut0(
		.clk(clk),
		.reset(reset),
		.strand_enable(strand_enable),
		.fetch(fetch),
		.rollback(rollback),
		.instruction_req(instruction_req),
		.issue(issue),
		.issue_event(issue_event)
	);

	always #2 clk = ~clk;

	task automatic tick(int n);
		repeat (n) @(posedge clk);
		#0.5;
	endtask

	function automatic fetch_slot_t slot_of(int s);
		return (ptr[s] < len[s]) ? prog[s][ptr[s]] : '0;
	endfunction

	function automatic bit drained(logic [N - 1:0] mask);
		for (int s = 0; s < N; s++)
		begin
			if (mask[s] && exp_ptr[s] < len[s])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// Random pcs and mixes with one strided entry at strided_at
	task automatic load_program(int s, int n, int long_pct, int strided_at);
		for (int i = 0; i < n; i++)
		begin
			prog[s][i].valid = 1'b1;
			prog[s][i].instruction = {(i == strided_at) ? `STRIDED_OPCODE : 4'h1, 28'($urandom)};
			prog[s][i].pc = $urandom & 32'hfffffffc;
			prog[s][i].branch_predicted = 1'($urandom);
			prog[s][i].long_latency = i != strided_at && $urandom_range(99) < long_pct;
		end
		len[s] = n;
		ptr[s] = 0;
		exp_ptr[s] = 0;
		step[s] = 0;
		start_lane[s] = 4'd15;
		start_off[s] = 32'd0;
		fetch[s] = slot_of(s);
	endtask

	task automatic wait_drained(logic [N - 1:0] mask);
		int n;
		n = 0;
		while (!drained(mask) && n < 300)
		begin
			tick(1);
			n++;
		end
		if (!drained(mask))
		begin
			errors++;
			$display("Timeout: strands %b did not finish their programs", mask);
		end
	endtask

	// Fetch model presents the next entry the cycle after instruction_req
	always @(negedge clk)
		req_seen = instruction_req;

	always @(posedge clk)
	begin
		#0.5;
		for (int s = 0; s < N; s++)
		begin
			if (req_seen[s])
				ptr[s]++;
			fetch[s] = slot_of(s);
		end
	end

	// Checker sees the output of the previous cycle's grant
	always @(negedge clk)
	begin
		int s;
		fetch_slot_t exp;
		logic [3:0] exp_lane;
		logic [N - 1:0] exp_req;
		if (!reset)
		begin
			checks++;
			exp_req = '0;
			assert (conflict_free(long_hist, issue_event, issue.long_latency, issue.instruction))
			else
			begin
				errors++;
				$display("Fail %0t: short issue three slots after a long issue", $time);
			end
			long_hist = {long_hist[1:0], issue_event && issue.long_latency};
			if (!issue_event)
			begin
				assert (issue.instruction == `NOP && issue.pc == 0 && issue.strand == 0
					&& !issue.branch_predicted && !issue.long_latency)
				else
				begin
					errors++;
					$display("Fail %0t: idle packet is not a NOP", $time);
				end
			end
			else
			begin
				s = issue.strand;
				assert (en_seen[s] && !suspended[s] && exp_ptr[s] < len[s])
				else
				begin
					errors++;
					$display("Fail %0t: unexpected issue from strand %0d", $time, s);
				end
				if (rr_check)
				begin
					assert (s == next_rr(last_winner, en_seen & ~drained_mask()))
					else
					begin
						errors++;
						$display("Fail %0t: strand %0d out of round-robin order", $time, s);
					end
				end
				last_winner = s;
				exp = prog[s][exp_ptr[s]];
				exp_lane = strided_lane(start_lane[s], step[s]);
				assert (issue.pc == exp.pc && issue.instruction == exp.instruction
					&& issue.branch_predicted == exp.branch_predicted
					&& issue.long_latency == exp.long_latency)
				else
				begin
					errors++;
					$display("Fail %0t: strand %0d pc %h instr %h, expected %h %h", $time, s,
						issue.pc, issue.instruction, exp.pc, exp.instruction);
				end
				assert (issue.reg_lane == exp_lane
					&& issue.strided_offset == strided_offset_at(start_off[s], step[s]))
				else
				begin
					errors++;
					$display("Fail %0t: strand %0d lane %0d offset %0d, expected %0d %0d", $time,
						s, issue.reg_lane, issue.strided_offset, exp_lane,
						strided_offset_at(start_off[s], step[s]));
				end
				if (exp.instruction[31:28] == `STRIDED_OPCODE && exp_lane != 4'd0)
					step[s]++;
				else
				begin
					// Slot consumed and lane walk restarts at the top
					exp_req[s] = 1'b1;
					exp_ptr[s]++;
					step[s] = 0;
					start_lane[s] = 4'd15;
					start_off[s] = 32'd0;
				end
			end
			// Fetch request pulses only with the grant that uses up the slot
			assert (req_prev == exp_req)
			else
			begin
				errors++;
				$display("Fail %0t: instruction_req %b, expected %b", $time, req_prev, exp_req);
			end
			req_prev = instruction_req;
			en_seen = strand_enable;
		end
	end

	function automatic logic [N - 1:0] drained_mask();
		logic [N - 1:0] m;
		for (int s = 0; s < N; s++)
			m[s] = exp_ptr[s] >= len[s];
		return m;
	endfunction

	initial
	begin
		void'($urandom(32'hae10707b));
		reset = 1'b1;
		strand_enable = '0;
		fetch = '0;
		rollback = '0;
		rr_check = 1'b0;
		errors = 0;
		checks = 0;
		long_hist = '0;
		en_seen = '0;
		suspended = '0;
		req_seen = '0;
		req_prev = '0;
		for (int s = 0; s < N; s++)
		begin
			len[s] = 0;
			ptr[s] = 0;
			exp_ptr[s] = 0;
			step[s] = 0;
			start_lane[s] = 4'd15;
			start_off[s] = 32'd0;
		end
		tick(10);
		reset = 1'b0;

		// All disabled and then strand 2 alone
		load_program(2, 6, 0, -1);
		tick(20);
		strand_enable = 4'b0100;
		wait_drained(4'b0100);

		// Round-robin over four always ready strands
		for (int s = 0; s < N; s++)
			load_program(s, 6, 0, -1);
		tick(3);
		rr_check = 1'b1;
		strand_enable = 4'b1111;
		wait_drained(4'b1111);
		rr_check = 1'b0;

		// One strided walk between short ops
		load_program(0, 3, 0, 0);
		strand_enable = 4'b0001;
		wait_drained(4'b0001);

		// Random long and short mix
		for (int s = 0; s < N; s++)
			load_program(s, 12, 50, -1);
		strand_enable = 4'b1111;
		wait_drained(4'b1111);

		// Strands 0 and 2 stay disabled with pending work
		// Strand 1 runs alone up to the rollback point
		for (int s = 0; s < N; s++)
			load_program(s, (s == 1) ? 3 : 6, 30, (s == 1) ? 1 : -1);
		strand_enable = 4'b0010;
		k = $urandom_range(8, 2);
		for (int n = 0; n < 100 && !(exp_ptr[1] == 1 && step[1] >= k); n++)
			tick(1);
		assert (exp_ptr[1] == 1 && step[1] >= k)
		else
		begin
			errors++;
			$display("Timeout: strided walk on strand 1 never reached the rollback point");
		end

		// Rollback strand 1 to lane 7 and offset 32 while it is idle
		strand_enable = 4'b1000;
		tick(2);
		rollback[1].rollback = 1'b1;
		rollback[1].reg_lane = 4'd7;
		rollback[1].strided_offset = 32'd32;
		start_lane[1] = 4'd7;
		start_off[1] = 32'd32;
		step[1] = 0;
		tick(1);
		rollback[1] = '0;
		strand_enable = 4'b1010;

		// Suspend strand 3 for a random stretch
		tick($urandom_range(4, 1));
		strand_enable = 4'b0010;
		tick(2);
		rollback[3].suspend = 1'b1;
		suspended[3] = 1'b1;
		tick(1);
		rollback[3].suspend = 1'b0;
		strand_enable = 4'b1010;
		tick($urandom_range(16, 8));
		rollback[3].resume = 1'b1;
		suspended[3] = 1'b0;
		tick(1);
		rollback[3].resume = 1'b0;
		wait_drained(4'b1010);
		tick(5);

		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* strand_select.f */
+incdir+.
strand_pkg.sv
strand_fsm.sv
issue_arbiter.sv
strand_select_stage.sv
strand_select_tb.sv
